/* Makefile */
# Verilator simulation of the VP8 coefficient quantizer

VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_vp8_quant_top
FILELIST  = filelist.f
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_MSG  = TEST RESULT: PASS

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* filelist.f */
source/vp8_quant_pkg.sv
source/quant_param_regs.sv
source/quantize_block.sv
source/coeff_scan_stats.sv
source/vp8_quant_top.sv
sim/tb_vp8_quant_top.sv

/* sim/tb_vp8_quant_top.sv */
// Self-checking testbench for vp8_quant_top, random blocks checked against a quantizer model
module tb_vp8_quant_top
    import vp8_quant_pkg::*;
;
    timeunit 1ns;
    timeprecision 100ps;

    typedef struct packed {
        block_t    levels;
        block_t    recon;
        count_t    count;
        scan_idx_t last;
        int        start_cyc;
    } expect_t;

    // ------------------------------------------------------------------
    // Run length and timeout budget
    // ------------------------------------------------------------------
    localparam int RESET_CYCLES = 8;
    localparam int N_SINGLE     = 8;
    localparam int N_STREAM     = 200;
    localparam int MAX_GAP      = 3;
    localparam int PARAM_CYCLES = 12;
    localparam int BLOCK_CYCLES = 6;
    localparam int PHASE_CYCLES = RESET_CYCLES + 4 + 6 * PARAM_CYCLES
                                + (N_SINGLE + 3 + NUM_COEFFS) * BLOCK_CYCLES
                                + N_STREAM * (MAX_GAP + 2) + 2 * BLOCK_CYCLES;
    localparam int TIMEOUT_CYCLES = 2 * PHASE_CYCLES + 100;

    // Raster position feeding each scan position
    localparam int SCAN_ORDER [16] = '{0, 1, 4, 8, 5, 2, 3, 6, 9, 12, 13, 10, 7, 11, 14, 15};

    logic          clk;
    logic          rst_n;
    logic          param_we_i;
    param_addr_t   param_addr_i;
    logic [31:0]   param_data_i;
    logic          start_i;
    block_t        coeffs_i;
    block_t        levels_o;
    block_t        recon_o;
    logic          done_o;
    logic          nz_o;
    count_t        nz_count_o;
    scan_idx_t     last_pos_o;
    logic          stats_valid_o;

    quant_params_t dc_model;
    quant_params_t ac_model;
    expect_t       level_q [$];
    expect_t       stats_q [$];
    logic [31:0]   lcg_state = 32'd2500;
    int            cycle_count = 0;
    int            mismatch_count = 0;
    int            fault_count = 0;

    vp8_quant_top vp8_quant_top_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .param_we_i    (param_we_i),
        .param_addr_i  (param_addr_i),
        .param_data_i  (param_data_i),
        .start_i       (start_i),
        .coeffs_i      (coeffs_i),
        .levels_o      (levels_o),
        .recon_o       (recon_o),
        .done_o        (done_o),
        .nz_o          (nz_o),
        .nz_count_o    (nz_count_o),
        .last_pos_o    (last_pos_o),
        .stats_valid_o (stats_valid_o)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state ^ (lcg_state >> 15);
    endfunction

    // ------------------------------------------------------------------
    // Reference model of the quantizer rules
    // ------------------------------------------------------------------
    function automatic expect_t model_block(input block_t coeffs, input int start_cyc);
        expect_t       want;
        block_t        raster;
        quant_params_t p;
        longint        mag;
        longint        lvl;
        longint        prod;
        logic          neg;
        int            count;
        int            last;
        count = 0;
        last  = 0;
        for (int i = 0; i < NUM_COEFFS; i++) begin
            p   = (i == 0) ? dc_model : ac_model;
            neg = coeffs[i] < 0;
            mag = neg ? -longint'(coeffs[i]) : longint'(coeffs[i]);
            mag = mag + longint'(p.sharpen);
            lvl = (mag * longint'(p.iq) + longint'(p.bias)) >>> QFIX;
            if (lvl > MAX_LEVEL) lvl = MAX_LEVEL;
            // Threshold applies to the sharpened magnitude
            if (mag <= longint'(p.zthresh)) lvl = 0;
            if (neg) lvl = -lvl;
            prod           = lvl * longint'(p.q);
            raster[i]      = coeff_t'(lvl);
            want.recon[i]  = prod[15:0];
        end
        for (int s = 0; s < NUM_COEFFS; s++) begin
            want.levels[s] = raster[SCAN_ORDER[s]];
            if (want.levels[s] != 0) begin
                count = count + 1;
                last  = s;
            end
        end
        want.count     = count_t'(count);
        want.last      = scan_idx_t'(last);
        want.start_cyc = start_cyc;
        return want;
    endfunction

    function automatic block_t random_block();
        block_t      blk;
        logic [31:0] r;
        for (int i = 0; i < NUM_COEFFS; i++) begin
            r = next_rand();
            if (r[31:30] == 2'd0) blk[i] = '0;
            else if (r[31:30] == 2'd1) blk[i] = coeff_t'({{8{r[7]}}, r[7:0]});
            else blk[i] = coeff_t'(r[15:0]);
        end
        return blk;
    endfunction

    function automatic quant_params_t random_params();
        quant_params_t p;
        logic [31:0]   r1;
        logic [31:0]   r2;
        r1        = next_rand();
        r2        = next_rand();
        p.q       = {8'd0, r1[7:0]} + 16'd1;
        p.iq      = r2[31:16];
        p.bias    = {14'd0, r2[17:0]};
        p.zthresh = {22'd0, r1[17:8]};
        p.sharpen = {12'd0, r1[21:18]};
        return p;
    endfunction

    task automatic check_value(input logic [255:0] actual, input logic [255:0] expected,
                               input string what);
        if (actual !== expected) begin
            mismatch_count++;
            $display("MISMATCH at %0t: %s got %0h expected %0h", $time, what, actual, expected);
        end
    endtask

    task automatic report_and_finish(input bit timed_out);
        $display("Errors: %0d mismatches, %0d other failures", mismatch_count, fault_count);
        if (!timed_out && mismatch_count == 0 && fault_count == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    endtask

    // ------------------------------------------------------------------
    // Stimulus tasks
    // ------------------------------------------------------------------
    task automatic write_param(input logic set_ac, input param_field_t field,
                               input logic [31:0] data);
        @(posedge clk);
        param_we_i   <= 1'b1;
        param_addr_i <= {set_ac, field};
        param_data_i <= data;
    endtask

    task automatic load_params(input logic set_ac, input quant_params_t p);
        write_param(set_ac, FIELD_Q, {16'd0, p.q});
        write_param(set_ac, FIELD_IQ, {16'd0, p.iq});
        write_param(set_ac, FIELD_BIAS, p.bias);
        write_param(set_ac, FIELD_ZTHRESH, p.zthresh);
        write_param(set_ac, FIELD_SHARPEN, {16'd0, p.sharpen});
        @(posedge clk);
        param_we_i <= 1'b0;
        if (set_ac) ac_model = p;
        else dc_model = p;
    endtask

    task automatic start_block(input block_t coeffs);
        expect_t want;
        @(posedge clk);
        coeffs_i <= coeffs;
        start_i  <= 1'b1;
        // Block is visible to the DUT during the next cycle
        want = model_block(coeffs, cycle_count + 1);
        level_q.push_back(want);
        stats_q.push_back(want);
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            start_i <= 1'b0;
        end
    endtask

    task automatic wait_idle();
        while (stats_q.size() != 0) @(negedge clk);
    endtask

    task automatic run_single(input block_t coeffs);
        start_block(coeffs);
        idle_cycles(1);
        wait_idle();
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count > TIMEOUT_CYCLES) begin
            $display("Run did not finish within %0d cycles", TIMEOUT_CYCLES);
            report_and_finish(1'b1);
        end
    end

    // Scoreboard, outputs are stable at the falling edge
    always @(negedge clk) begin : scoreboard
        expect_t want;
        if (rst_n && done_o) begin
            if (level_q.size() == 0) begin
                fault_count++;
                $display("done_o pulsed at %0t with no block outstanding", $time);
            end else begin
                want = level_q.pop_front();
                check_value(256'(cycle_count), 256'(want.start_cyc + 2), "done_o latency");
                check_value(levels_o, want.levels, "levels_o");
                check_value(recon_o, want.recon, "recon_o");
            end
        end
        if (rst_n && stats_valid_o) begin
            if (stats_q.size() == 0) begin
                fault_count++;
                $display("stats_valid_o pulsed at %0t with no block outstanding", $time);
            end else begin
                want = stats_q.pop_front();
                check_value(256'(cycle_count), 256'(want.start_cyc + 3), "stats latency");
                check_value(256'(nz_o), 256'(want.count != 0), "nz_o");
                check_value(256'(nz_count_o), 256'(want.count), "nz_count_o");
                check_value(256'(last_pos_o), 256'(want.last), "last_pos_o");
            end
        end
    end

    initial begin
        block_t        blk;
        quant_params_t p;
        logic [31:0]   r;
        int            v;
        int            pos;
        rst_n        = 1'b0;
        param_we_i   = 1'b0;
        param_addr_i = '0;
        param_data_i = '0;
        start_i      = 1'b0;
        coeffs_i     = '0;
        dc_model     = '0;
        ac_model     = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;

        // Idle outputs after reset
        repeat (4) begin
            @(negedge clk);
            check_value(levels_o, '0, "levels_o after reset");
            check_value(recon_o, '0, "recon_o after reset");
            check_value(256'({done_o, stats_valid_o, nz_o, nz_count_o, last_pos_o}), '0,
                        "flags after reset");
        end

        // Distinct DC and AC sets
        load_params(SET_DC, random_params());
        load_params(SET_AC, random_params());
        for (int n = 0; n < N_SINGLE; n++) run_single(random_block());

        // ------------------------------------------------------------------
        // Clamp, then zero threshold
        // ------------------------------------------------------------------
        p = '{q: 16'd3, iq: 16'hffff, bias: 32'd0, zthresh: 32'd0, sharpen: 16'd0};
        load_params(SET_DC, p);
        load_params(SET_AC, p);
        for (int i = 0; i < NUM_COEFFS; i++) begin
            r      = next_rand();
            v      = 20000 + int'(r[12:0]);
            blk[i] = coeff_t'(r[31] ? -v : v);
        end
        run_single(blk);
        for (int s = 0; s < NUM_COEFFS; s++) begin
            check_value(256'(levels_o[s]),
                        256'(blk[SCAN_ORDER[s]] < 0 ? -16'sd2047 : 16'sd2047), "clamped level");
        end

        p = '{q: 16'd5, iq: 16'hffff, bias: 32'd0, zthresh: 32'd500, sharpen: 16'd0};
        load_params(SET_DC, p);
        load_params(SET_AC, p);
        for (int i = 0; i < NUM_COEFFS; i++) begin
            r      = next_rand();
            blk[i] = coeff_t'(int'(r % 32'd1001) - 500);
        end
        run_single(blk);
        check_value(levels_o, '0, "levels below threshold");
        check_value(recon_o, '0, "recon below threshold");

        // One nonzero coefficient per block, walked over every raster position
        p = '{q: 16'd10, iq: 16'd13107, bias: 32'd0, zthresh: 32'd0, sharpen: 16'd0};
        load_params(SET_DC, p);
        load_params(SET_AC, p);
        for (int raster_pos = 0; raster_pos < NUM_COEFFS; raster_pos++) begin
            blk             = '0;
            blk[raster_pos] = (raster_pos % 2 == 1) ? -16'sd1000 : 16'sd1000;
            run_single(blk);
            for (int s = 0; s < NUM_COEFFS; s++) begin
                if (SCAN_ORDER[s] == raster_pos) pos = s;
            end
            check_value(256'(last_pos_o), 256'(pos), "single coefficient last_pos_o");
            check_value(256'(nz_count_o), 256'(1), "single coefficient nz_count_o");
        end
        run_single('0);

        // Back-to-back blocks, then random gaps
        load_params(SET_DC, random_params());
        load_params(SET_AC, random_params());
        for (int n = 0; n < N_STREAM; n++) start_block(random_block());
        idle_cycles(1);
        wait_idle();
        load_params(SET_DC, random_params());
        load_params(SET_AC, random_params());
        for (int n = 0; n < N_STREAM; n++) begin
            start_block(random_block());
            r = next_rand();
            idle_cycles(int'(r[1:0]));
        end
        idle_cycles(1);
        wait_idle();

        repeat (2) @(posedge clk);
        if (level_q.size() != 0 || stats_q.size() != 0) begin
            fault_count++;
            $display("Blocks still outstanding at end: %0d levels, %0d stats",
                     level_q.size(), stats_q.size());
        end
        report_and_finish(1'b0);
    end

endmodule

/* source/coeff_scan_stats.sv */
// Registers the nonzero flag, count and last nonzero scan index of each zigzag level block
module coeff_scan_stats
    import vp8_quant_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      levels_valid_i,
    input  block_t    levels_i,
    output logic      nz_o,
    output count_t    nz_count_o,
    output scan_idx_t last_pos_o,
    output logic      stats_valid_o
);

    count_t    count_d;
    scan_idx_t last_d;
    logic      nz_d;

    // ------------------------------------------------------------------
    // Scan over all positions
    // ------------------------------------------------------------------
    always_comb begin
        count_d = '0;
        last_d  = '0;
        for (int s = 0; s < NUM_COEFFS; s++) begin
            if (levels_i[s] != '0) begin
                count_d = count_d + count_t'(1);
                // Later positions overwrite earlier ones so the highest remains
                last_d  = scan_idx_t'(s);
            end
        end
    end

    // Any nonzero bit in the whole block
    assign nz_d = (levels_i != '0);

    // ------------------------------------------------------------------
    // Output registers
    // ------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            nz_o          <= 1'b0;
            nz_count_o    <= '0;
            last_pos_o    <= '0;
            stats_valid_o <= 1'b0;
        end else begin
            stats_valid_o <= levels_valid_i;
            if (levels_valid_i) begin
                nz_o       <= nz_d;
                nz_count_o <= count_d;
                last_pos_o <= last_d;
            end
        end
    end

    // Block-wide nonzero flag must agree with the count
    a_nz_matches_count: assert property (
        @(posedge clk) disable iff (!rst_n)
        stats_valid_o |-> (nz_o == (nz_count_o != '0))
    ) else $error("nz flag disagrees with count %0d", nz_count_o);

endmodule

/* source/quant_param_regs.sv */
// DC and AC quantizer parameter sets, loaded field by field through address write strobes
module quant_param_regs
    import vp8_quant_pkg::*;
(
    input  logic          clk,
    input  logic          rst_n,
    input  logic          param_we_i,
    input  param_addr_t   param_addr_i,
    input  logic [31:0]   param_data_i,
    output quant_params_t dc_params_o,
    output quant_params_t ac_params_o
);

    quant_params_t dc_params_q;
    quant_params_t ac_params_q;
    logic          set_sel;
    param_field_t  field_sel;

    // Upper address bit picks the set, lower three the field
    assign set_sel   = param_addr_i[3];
    assign field_sel = param_addr_i[2:0];

    // Replace one field, data truncated to the field width
    function automatic quant_params_t write_field(
        input quant_params_t cur,
        input param_field_t  field,
        input logic [31:0]   data
    );
        quant_params_t nxt;
        nxt = cur;
        case (field)
            FIELD_Q:       nxt.q       = data[15:0];
            FIELD_IQ:      nxt.iq      = data[15:0];
            FIELD_BIAS:    nxt.bias    = data;
            FIELD_ZTHRESH: nxt.zthresh = data;
            FIELD_SHARPEN: nxt.sharpen = data[15:0];
            default:       nxt         = cur;
        endcase
        return nxt;
    endfunction

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dc_params_q <= '0;
            ac_params_q <= '0;
        end else if (param_we_i) begin
            if (set_sel == SET_AC) begin
                ac_params_q <= write_field(ac_params_q, field_sel, param_data_i);
            end else begin
                dc_params_q <= write_field(dc_params_q, field_sel, param_data_i);
            end
        end
    end

    assign dc_params_o = dc_params_q;
    assign ac_params_o = ac_params_q;

    // Field codes 5 to 7 address nothing
    a_legal_field: assert property (
        @(posedge clk) disable iff (!rst_n)
        param_we_i |-> (param_addr_i[2:0] <= FIELD_SHARPEN)
    ) else $error("parameter write to illegal field code %0d", param_addr_i[2:0]);

endmodule

/* source/quantize_block.sv */
// Two-stage quantizer for one 4x4 block, levels out in zigzag order and recon in raster order
module quantize_block
    import vp8_quant_pkg::*;
(
    input  logic          clk,
    input  logic          rst_n,
    input  logic          start_i,
    input  block_t        coeffs_i,
    input  quant_params_t dc_params_i,
    input  quant_params_t ac_params_i,
    output block_t        levels_o,
    output block_t        recon_o,
    output logic          done_o
);

    // Start delay line, bit 0 qualifies stage 2
    logic [1:0] start_sr;

    // Stage 1 inputs and registers
    logic       sign_d    [NUM_COEFFS];
    mag_t       mag_d     [NUM_COEFFS];
    mag_t       raw_lvl_d [NUM_COEFFS];
    logic       sign_q    [NUM_COEFFS];
    mag_t       mag_q     [NUM_COEFFS];
    mag_t       raw_lvl_q [NUM_COEFFS];

    // Stage 2 inputs and raster level register
    coeff_t     level_d   [NUM_COEFFS];
    coeff_t     recon_d   [NUM_COEFFS];
    coeff_t     level_q   [NUM_COEFFS];

    // ------------------------------------------------------------------
    // Per-lane datapath
    // ------------------------------------------------------------------
    for (genvar i = 0; i < NUM_COEFFS; i++) begin : g_lane
        quant_params_t      p;
        logic signed [16:0] coeff_ext;
        mag_t               abs_coeff;
        logic [33:0]        scaled;
        ulevel_t            clamped;
        coeff_t             signed_lvl;
        logic signed [31:0] recon_full;

        // DC lane has its own parameter set
        assign p = (i == 0) ? dc_params_i : ac_params_i;

        // Stage 1: sharpen and scale
        assign coeff_ext    = {coeffs_i[i][15], coeffs_i[i]};
        assign sign_d[i]    = coeffs_i[i][15];
        assign abs_coeff    = sign_d[i] ? mag_t'(-coeff_ext) : mag_t'(coeff_ext);
        assign mag_d[i]     = abs_coeff + mag_t'(p.sharpen);
        assign scaled       = 34'(mag_d[i]) * 34'(p.iq) + 34'(p.bias);
        assign raw_lvl_d[i] = scaled[QFIX +: 17];

        // Stage 2: clamp, threshold, sign, dequantize
        assign clamped    = (raw_lvl_q[i] > mag_t'(MAX_LEVEL)) ? ulevel_t'(MAX_LEVEL)
                                                               : raw_lvl_q[i][10:0];
        assign signed_lvl = sign_q[i] ? -coeff_t'(clamped) : coeff_t'(clamped);
        assign level_d[i] = (32'(mag_q[i]) > p.zthresh) ? signed_lvl : '0;
        assign recon_full = 32'(level_d[i]) * $signed({16'd0, p.q});
        // Reconstruction keeps the low 16 bits of the product
        assign recon_d[i] = recon_full[15:0];

        a_level_range: assert property (
            @(posedge clk) disable iff (!rst_n)
            done_o |-> (level_q[i] <= MAX_LEVEL && level_q[i] >= -MAX_LEVEL)
        ) else $error("lane %0d level %0d exceeds clamp", i, level_q[i]);
    end

    // ------------------------------------------------------------------
    // Pipeline registers
    // ------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            start_sr <= '0;
        end else begin
            start_sr <= {start_sr[0], start_i};
        end
    end

    // Stage 1 loads only on start, inputs need not stay valid
    always_ff @(posedge clk) begin
        if (start_i) begin
            for (int i = 0; i < NUM_COEFFS; i++) begin
                sign_q[i]    <= sign_d[i];
                mag_q[i]     <= mag_d[i];
                raw_lvl_q[i] <= raw_lvl_d[i];
            end
        end
    end

    // Stage 2 results hold until the next block
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_COEFFS; i++) begin
                level_q[i] <= '0;
            end
            recon_o <= '0;
        end else if (start_sr[0]) begin
            for (int i = 0; i < NUM_COEFFS; i++) begin
                level_q[i] <= level_d[i];
                recon_o[i] <= recon_d[i];
            end
        end
    end

    // Zigzag reorder is pure wiring
    for (genvar s = 0; s < NUM_COEFFS; s++) begin : g_scan
        assign levels_o[s] = level_q[ZIGZAG[s]];
    end

    assign done_o = start_sr[1];

endmodule

/* source/vp8_quant_pkg.sv */
// Shared geometry, types and scan table for the VP8 coefficient quantizer, imported by all RTL
package vp8_quant_pkg;

    // ------------------------------------------------------------------
    // Block geometry and fixed-point constants
    // ------------------------------------------------------------------
    localparam int NUM_COEFFS = 16;
    localparam int MAX_LEVEL  = 2047;
    localparam int QFIX       = 17;

    // Coefficient, level and reconstruction all share this width
    typedef logic signed [15:0] coeff_t;
    typedef coeff_t [NUM_COEFFS-1:0] block_t;

    // Sharpened magnitude, |coeff| + sharpen fits in 17 bits
    typedef logic [16:0] mag_t;

    // Level magnitude after clamping
    typedef logic [10:0] ulevel_t;

    // ------------------------------------------------------------------
    // Parameter register addressing
    // ------------------------------------------------------------------
    typedef logic [3:0] param_addr_t;
    typedef logic [2:0] param_field_t;

    localparam logic SET_DC = 1'b0;
    localparam logic SET_AC = 1'b1;

    localparam param_field_t FIELD_Q       = 3'd0;
    localparam param_field_t FIELD_IQ      = 3'd1;
    localparam param_field_t FIELD_BIAS    = 3'd2;
    localparam param_field_t FIELD_ZTHRESH = 3'd3;
    localparam param_field_t FIELD_SHARPEN = 3'd4;

    typedef struct packed {
        logic [15:0] q;
        logic [15:0] iq;
        logic [31:0] bias;
        logic [31:0] zthresh;
        logic [15:0] sharpen;
    } quant_params_t;

    // Scan statistics
    typedef logic [3:0] scan_idx_t;
    typedef logic [4:0] count_t;

    // Raster position read by each zigzag scan position
    localparam scan_idx_t ZIGZAG [NUM_COEFFS] = '{
        4'd0, 4'd1, 4'd4, 4'd8, 4'd5, 4'd2, 4'd3, 4'd6,
        4'd9, 4'd12, 4'd13, 4'd10, 4'd7, 4'd11, 4'd14, 4'd15
    };

endpackage

/* source/vp8_quant_top.sv */
// Quantizer subsystem top, parameter registers feeding the block quantizer and scan statistics
module vp8_quant_top
    import vp8_quant_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        param_we_i,
    input  param_addr_t param_addr_i,
    input  logic [31:0] param_data_i,
    input  logic        start_i,
    input  block_t      coeffs_i,
    output block_t      levels_o,
    output block_t      recon_o,
    output logic        done_o,
    output logic        nz_o,
    output count_t      nz_count_o,
    output scan_idx_t   last_pos_o,
    output logic        stats_valid_o
);

    quant_params_t dc_params;
    quant_params_t ac_params;

    quant_param_regs quant_param_regs_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .param_we_i   (param_we_i),
        .param_addr_i (param_addr_i),
        .param_data_i (param_data_i),
        .dc_params_o  (dc_params),
        .ac_params_o  (ac_params)
    );

    // Levels and recon valid two cycles after start
    quantize_block quantize_block_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .start_i     (start_i),
        .coeffs_i    (coeffs_i),
        .dc_params_i (dc_params),
        .ac_params_i (ac_params),
        .levels_o    (levels_o),
        .recon_o     (recon_o),
        .done_o      (done_o)
    );

    // Statistics follow one cycle later
    coeff_scan_stats coeff_scan_stats_inst (
        .clk            (clk),
        .rst_n          (rst_n),
        .levels_valid_i (done_o),
        .levels_i       (levels_o),
        .nz_o           (nz_o),
        .nz_count_o     (nz_count_o),
        .last_pos_o     (last_pos_o),
        .stats_valid_o  (stats_valid_o)
    );

endmodule
